/* hw/bram.sv */
`default_nettype none
`include "soc_params.svh"

module bram
	import soc_pkg::*;
#(
	parameter int WORDS = `SOC_RAM_WORDS
) (
	input  wire                    i_clock,
	input  wire                    i_request,
	input  wire                    i_rw,
	input  wire  [`SOC_ADDR_W-1:0] i_address,
	input  wire  [`SOC_DATA_W-1:0] i_wdata,
	output logic [`SOC_DATA_W-1:0] o_rdata,
	output logic                   o_ready
);

	localparam int IDX_W = $clog2(WORDS);

	logic [`SOC_DATA_W-1:0] mem [WORDS];
	logic [IDX_W-1:0] index;
	logic access;

	// Word index, wraps modulo WORDS for a power-of-two size
	assign index = i_address[IDX_W+1:2];

	// Request stays high in the ready cycle; do not take it twice
	assign access = i_request && !o_ready;

	always_ff @(posedge i_clock) begin
		o_ready <= access;
		if (access) begin
			if (i_rw)
				mem[index] <= i_wdata;
			o_rdata <= mem[index];
		end
	end

	a_ready_after_req: assert property (@(posedge i_clock)
		o_ready |-> $past(i_request));

endmodule

`default_nettype wire

/* hw/bus_access.sv */
`default_nettype none
`include "soc_params.svh"

module bus_access
	import soc_pkg::*;
(
	input  wire                    i_clock,
	input  wire                    i_reset,

	// Port A, instruction reads
	input  wire                    i_pa_request,
	input  wire  [`SOC_ADDR_W-1:0] i_pa_address,
	output logic                   o_pa_ready,
	output logic [`SOC_DATA_W-1:0] o_pa_rdata,

	// Port B, data reads and writes
	input  wire                    i_pb_request,
	input  wire                    i_pb_rw,
	input  wire  [`SOC_ADDR_W-1:0] i_pb_address,
	input  wire  [`SOC_DATA_W-1:0] i_pb_wdata,
	output logic                   o_pb_ready,
	output logic [`SOC_DATA_W-1:0] o_pb_rdata,

	// Shared bus
	output logic                   o_bus_request,
	output logic                   o_bus_rw,
	output logic [`SOC_ADDR_W-1:0] o_bus_address,
	output logic [`SOC_DATA_W-1:0] o_bus_wdata,
	output bus_owner_e             o_bus_owner,
	input  wire                    i_bus_ready,
	input  wire  [`SOC_DATA_W-1:0] i_bus_rdata
);

	arb_state_e state;
	logic req_a;
	logic req_b;
	logic pick_b;

	// A port's request is still up in its ready cycle, so mask it there
	assign req_a = i_pa_request && !o_pa_ready;
	assign req_b = i_pb_request && !o_pb_ready;

	// Round robin with the owner register as the last winner
	assign pick_b = req_b && (!req_a || o_bus_owner == OWNER_A);

	//======================================================================
	// Arbiter FSM
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= IDLE;
			o_bus_request <= 1'b0;
			o_bus_owner <= OWNER_B;
			o_pa_ready <= 1'b0;
			o_pb_ready <= 1'b0;
		end else begin
			o_pa_ready <= 1'b0;
			o_pb_ready <= 1'b0;
			case (state)
				IDLE: begin
					if (pick_b) begin
						state <= WAIT_B;
						o_bus_owner <= OWNER_B;
						o_bus_request <= 1'b1;
					end else if (req_a) begin
						state <= WAIT_A;
						o_bus_owner <= OWNER_A;
						o_bus_request <= 1'b1;
					end
				end
				WAIT_A: begin
					if (i_bus_ready) begin
						state <= IDLE;
						o_bus_request <= 1'b0;
						o_pa_ready <= 1'b1;
					end
				end
				WAIT_B: begin
					if (i_bus_ready) begin
						state <= IDLE;
						o_bus_request <= 1'b0;
						o_pb_ready <= 1'b1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	//======================================================================
	// Address, write data and read data
	always_ff @(posedge i_clock) begin
		if (state == IDLE) begin
			if (pick_b) begin
				o_bus_rw <= i_pb_rw;
				o_bus_address <= i_pb_address;
				o_bus_wdata <= i_pb_wdata;
			end else begin
				// Port A only reads
				o_bus_rw <= 1'b0;
				o_bus_address <= i_pa_address;
				o_bus_wdata <= '0;
			end
		end
		if (state == WAIT_A && i_bus_ready)
			o_pa_rdata <= i_bus_rdata;
		if (state == WAIT_B && i_bus_ready)
			o_pb_rdata <= i_bus_rdata;
	end

	//======================================================================
	// Checks
	a_single_ready: assert property (@(posedge i_clock) disable iff (i_reset)
		!(o_pa_ready && o_pb_ready));

endmodule

`default_nettype wire

/* hw/bus_decode.sv */
`default_nettype none
`include "soc_params.svh"

module bus_decode
	import soc_pkg::*;
(
	input  wire                    i_clock,
	input  wire                    i_reset,

	// Shared bus
	input  wire                    i_bus_request,
	input  wire  [`SOC_ADDR_W-1:0] i_bus_address,
	input  wire  bus_owner_e       i_bus_owner,
	output logic                   o_bus_ready,
	output logic [`SOC_DATA_W-1:0] o_bus_rdata,

	// Targets
	output logic                   o_ram_request,
	input  wire                    i_ram_ready,
	input  wire  [`SOC_DATA_W-1:0] i_ram_rdata,
	output logic                   o_bridge_request,
	input  wire                    i_bridge_ready,
	input  wire  [`SOC_DATA_W-1:0] i_bridge_rdata,

	// Sticky fault
	output logic                   o_bus_fault,
	output logic [`SOC_ADDR_W-1:0] o_fault_address,
	output fault_src_e             o_fault_src
);

	logic [3:0] nibble;
	logic ram_sel;
	logic bridge_sel;
	logic unmapped;

	assign nibble = i_bus_address[`SOC_ADDR_W-1 -: 4];
	assign ram_sel = nibble == 4'(`SOC_SEL_RAM);
	assign bridge_sel = nibble == 4'(`SOC_SEL_BRIDGE);
	assign unmapped = !ram_sel && !bridge_sel;

	assign o_ram_request = i_bus_request && ram_sel;
	assign o_bridge_request = i_bus_request && bridge_sel;

	// Unmapped accesses complete at once with zero
	assign o_bus_rdata =
		ram_sel    ? i_ram_rdata    :
		bridge_sel ? i_bridge_rdata :
		'0;

	assign o_bus_ready =
		ram_sel    ? i_ram_ready    :
		bridge_sel ? i_bridge_ready :
		i_bus_request;

	// Only the first fault is kept
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_bus_fault <= 1'b0;
			o_fault_address <= '0;
			o_fault_src <= FAULT_NONE;
		end else if (i_bus_request && unmapped && !o_bus_fault) begin
			o_bus_fault <= 1'b1;
			o_fault_address <= i_bus_address;
			o_fault_src <= (i_bus_owner == OWNER_A) ? FAULT_IBUS : FAULT_DBUS;
		end
	end

endmodule

`default_nettype wire

/* hw/io_bridge.sv */
`default_nettype none
`include "soc_params.svh"

module io_bridge
	import soc_pkg::*;
(
	input  wire                    i_clock,
	input  wire                    i_reset,

	// Near side
	input  wire                    i_request,
	input  wire                    i_rw,
	input  wire  [27:0]            i_address,
	input  wire  [`SOC_DATA_W-1:0] i_wdata,
	output logic [`SOC_DATA_W-1:0] o_rdata,
	output logic                   o_ready,

	// Far side
	output logic                   o_far_request,
	output logic                   o_far_rw,
	output logic [27:0]            o_far_address,
	output logic [`SOC_DATA_W-1:0] o_far_wdata,
	input  wire                    i_timer_ready,
	input  wire  [`SOC_DATA_W-1:0] i_timer_rdata,

	output logic [`SOC_LED_W-1:0]  o_ledr
);

	logic busy;
	logic take;
	logic [3:0] far_nibble;
	logic led_sel;
	logic timer_sel;

	assign take = !busy && i_request && !o_ready;

	// Far decode on the captured address
	assign far_nibble = o_far_address[27:24];
	assign led_sel = far_nibble == 4'(`SOC_FAR_LED);
	assign timer_sel = far_nibble == 4'(`SOC_FAR_TIMER);

	//======================================================================
	// Transaction control
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			busy <= 1'b0;
			o_far_request <= 1'b0;
			o_ready <= 1'b0;
			o_ledr <= '0;
		end else begin
			o_ready <= 1'b0;
			if (take) begin
				busy <= 1'b1;
				o_far_request <= i_address[27:24] == 4'(`SOC_FAR_TIMER);
			end else if (busy && timer_sel) begin
				if (i_timer_ready) begin
					busy <= 1'b0;
					o_far_request <= 1'b0;
					o_ready <= 1'b1;
				end
			end else if (busy) begin
				// LED is local, unknown targets just answer
				if (led_sel && o_far_rw)
					o_ledr <= o_far_wdata[`SOC_LED_W-1:0];
				busy <= 1'b0;
				o_ready <= 1'b1;
			end
		end
	end

	//======================================================================
	// Captured request and response data
	always_ff @(posedge i_clock) begin
		if (take) begin
			o_far_rw <= i_rw;
			o_far_address <= i_address;
			o_far_wdata <= i_wdata;
		end
		if (busy) begin
			if (timer_sel)
				o_rdata <= i_timer_rdata;
			else if (led_sel)
				o_rdata <= {{(`SOC_DATA_W-`SOC_LED_W){1'b0}}, o_ledr};
			else
				o_rdata <= '0;
		end
	end

	a_far_ready: assert property (@(posedge i_clock) disable iff (i_reset)
		i_timer_ready |-> $past(o_far_request));

endmodule

`default_nettype wire

/* hw/soc.sv */
`default_nettype none
`include "soc_params.svh"

module soc
	import soc_pkg::*;
(
	input  wire                    i_clock,
	input  wire                    i_reset,

	// Port A
	input  wire                    i_pa_request,
	input  wire  [`SOC_ADDR_W-1:0] i_pa_address,
	output logic                   o_pa_ready,
	output logic [`SOC_DATA_W-1:0] o_pa_rdata,

	// Port B
	input  wire                    i_pb_request,
	input  wire                    i_pb_rw,
	input  wire  [`SOC_ADDR_W-1:0] i_pb_address,
	input  wire  [`SOC_DATA_W-1:0] i_pb_wdata,
	output logic                   o_pb_ready,
	output logic [`SOC_DATA_W-1:0] o_pb_rdata,

	output logic [`SOC_LED_W-1:0]  o_ledr,
	output logic                   o_timer_irq,
	output logic                   o_bus_fault,
	output logic [`SOC_ADDR_W-1:0] o_fault_address,
	output fault_src_e             o_fault_src
);

	//======================================================================
	// Shared bus
	logic bus_request;
	logic bus_rw;
	logic [`SOC_ADDR_W-1:0] bus_address;
	logic [`SOC_DATA_W-1:0] bus_wdata;
	logic [`SOC_DATA_W-1:0] bus_rdata;
	logic bus_ready;
	bus_owner_e bus_owner;

	// Targets
	logic ram_request;
	logic ram_ready;
	logic [`SOC_DATA_W-1:0] ram_rdata;
	logic bridge_request;
	logic bridge_ready;
	logic [`SOC_DATA_W-1:0] bridge_rdata;

	// Far bus
	logic far_request;
	logic far_rw;
	logic [27:0] far_address;
	logic [`SOC_DATA_W-1:0] far_wdata;
	logic timer_ready;
	logic [`SOC_DATA_W-1:0] timer_rdata;

	bus_access bus_access_inst (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_pa_request(i_pa_request),
		.i_pa_address(i_pa_address),
		.o_pa_ready(o_pa_ready),
		.o_pa_rdata(o_pa_rdata),
		.i_pb_request(i_pb_request),
		.i_pb_rw(i_pb_rw),
		.i_pb_address(i_pb_address),
		.i_pb_wdata(i_pb_wdata),
		.o_pb_ready(o_pb_ready),
		.o_pb_rdata(o_pb_rdata),
		.o_bus_request(bus_request),
		.o_bus_rw(bus_rw),
		.o_bus_address(bus_address),
		.o_bus_wdata(bus_wdata),
		.o_bus_owner(bus_owner),
		.i_bus_ready(bus_ready),
		.i_bus_rdata(bus_rdata)
	);

	bus_decode bus_decode_inst (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_bus_request(bus_request),
		.i_bus_address(bus_address),
		.i_bus_owner(bus_owner),
		.o_bus_ready(bus_ready),
		.o_bus_rdata(bus_rdata),
		.o_ram_request(ram_request),
		.i_ram_ready(ram_ready),
		.i_ram_rdata(ram_rdata),
		.o_bridge_request(bridge_request),
		.i_bridge_ready(bridge_ready),
		.i_bridge_rdata(bridge_rdata),
		.o_bus_fault(o_bus_fault),
		.o_fault_address(o_fault_address),
		.o_fault_src(o_fault_src)
	);

	bram #(
		.WORDS(`SOC_RAM_WORDS)
	) ram_inst (
		.i_clock(i_clock),
		.i_request(ram_request),
		.i_rw(bus_rw),
		.i_address(bus_address),
		.i_wdata(bus_wdata),
		.o_rdata(ram_rdata),
		.o_ready(ram_ready)
	);

	//======================================================================
	// Peripheral side
	io_bridge io_bridge_inst (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(bridge_request),
		.i_rw(bus_rw),
		.i_address(bus_address[27:0]),
		.i_wdata(bus_wdata),
		.o_rdata(bridge_rdata),
		.o_ready(bridge_ready),
		.o_far_request(far_request),
		.o_far_rw(far_rw),
		.o_far_address(far_address),
		.o_far_wdata(far_wdata),
		.i_timer_ready(timer_ready),
		.i_timer_rdata(timer_rdata),
		.o_ledr(o_ledr)
	);

	timer timer_inst (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(far_request),
		.i_rw(far_rw),
		.i_address(far_address[4:2]),
		.i_wdata(far_wdata),
		.o_rdata(timer_rdata),
		.o_ready(timer_ready),
		.o_irq(o_timer_irq)
	);

endmodule

`default_nettype wire

/* hw/soc_params.svh */
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// Bus widths
`define SOC_DATA_W 32
`define SOC_ADDR_W 32

// Near bus map, top address nibble
`define SOC_SEL_RAM    1
`define SOC_SEL_BRIDGE 5

// Far bus map, bits 27 to 24 behind the bridge
`define SOC_FAR_LED   0
`define SOC_FAR_TIMER 5

// Sizes
`define SOC_RAM_WORDS 512
`define SOC_LED_W     10

`endif

/* hw/soc_pkg.sv */
`default_nettype none

package soc_pkg;

	// Arbiter FSM
	typedef enum logic [1:0] {
		IDLE   = 2'd0,
		WAIT_A = 2'd1,
		WAIT_B = 2'd2
	} arb_state_e;

	// Which port holds the bus
	typedef enum logic {
		OWNER_A = 1'b0,
		OWNER_B = 1'b1
	} bus_owner_e;

	// Source of a latched bus fault
	typedef enum logic [1:0] {
		FAULT_NONE = 2'd0,
		FAULT_IBUS = 2'd1,
		FAULT_DBUS = 2'd2
	} fault_src_e;

endpackage

`default_nettype wire

/* hw/timer.sv */
`default_nettype none
`include "soc_params.svh"

module timer
	import soc_pkg::*;
(
	input  wire                    i_clock,
	input  wire                    i_reset,
	input  wire                    i_request,
	input  wire                    i_rw,
	input  wire  [2:0]             i_address,
	input  wire  [`SOC_DATA_W-1:0] i_wdata,
	output logic [`SOC_DATA_W-1:0] o_rdata,
	output logic                   o_ready,
	output logic                   o_irq
);

	// Register words
	localparam logic [2:0] WORD_COUNT   = 3'd0;
	localparam logic [2:0] WORD_COMPARE = 3'd1;

	logic [`SOC_DATA_W-1:0] counter;
	logic [`SOC_DATA_W-1:0] compare;
	logic access;

	assign access = i_request && !o_ready;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			counter <= '0;
			compare <= '1;
			o_ready <= 1'b0;
		end else begin
			counter <= counter + 1'b1;
			o_ready <= access;
			// Counter word is read only
			if (access && i_rw && i_address == WORD_COMPARE)
				compare <= i_wdata;
		end
	end

	always_ff @(posedge i_clock) begin
		if (access) begin
			case (i_address)
				WORD_COUNT:   o_rdata <= counter;
				WORD_COMPARE: o_rdata <= compare;
				default:      o_rdata <= '0;
			endcase
		end
	end

	// Level interrupt, clears when compare moves ahead
	assign o_irq = counter >= compare;

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tb_soc \
	--Mdir obj_dir -o tb_soc_sim \
	&& ./obj_dir/tb_soc_sim | tee /dev/stderr | grep -x "test passed" > /dev/null \
	&& { echo "PASS"; exit 0; } \
	|| { echo "FAIL"; exit 1; }

/* src.f */
+incdir+hw
hw/soc_pkg.sv
hw/bus_access.sv
hw/bus_decode.sv
hw/bram.sv
hw/io_bridge.sv
hw/timer.sv
hw/soc.sv
tb/tb_soc.sv

/* tb/tb_soc.sv */
`default_nettype none
`include "soc_params.svh"

module tb_soc
	import soc_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int N_WORDS = 64;
	localparam int N_PAIRS = 32;

	// Budget of 16 cycles per access and the interrupt wait
	localparam int N_ACCESSES = 3 * N_WORDS + 2 * N_PAIRS + 12;
	localparam int WATCHDOG_CYCLES = N_ACCESSES * 16 + 100 + 300;

	localparam logic [`SOC_ADDR_W-1:0] LED_ADDR =
		{4'(`SOC_SEL_BRIDGE), 4'(`SOC_FAR_LED), 24'h0};
	localparam logic [`SOC_ADDR_W-1:0] TIMER_COUNT =
		{4'(`SOC_SEL_BRIDGE), 4'(`SOC_FAR_TIMER), 24'h0};
	localparam logic [`SOC_ADDR_W-1:0] TIMER_COMPARE = TIMER_COUNT | 32'h4;

	logic i_clock = 1'b0;
	logic i_reset;
	logic i_pa_request;
	logic [`SOC_ADDR_W-1:0] i_pa_address;
	logic o_pa_ready;
	logic [`SOC_DATA_W-1:0] o_pa_rdata;
	logic i_pb_request;
	logic i_pb_rw;
	logic [`SOC_ADDR_W-1:0] i_pb_address;
	logic [`SOC_DATA_W-1:0] i_pb_wdata;
	logic o_pb_ready;
	logic [`SOC_DATA_W-1:0] o_pb_rdata;
	logic [`SOC_LED_W-1:0] o_ledr;
	logic o_timer_irq;
	logic o_bus_fault;
	logic [`SOC_ADDR_W-1:0] o_fault_address;
	fault_src_e o_fault_src;

	// Reference model
	logic [`SOC_DATA_W-1:0] ram_model [`SOC_RAM_WORDS];
	logic [`SOC_LED_W-1:0] led_model = '0;

	logic pa_check;
	logic pb_check;
	int checks;
	int errors;
	int read_checks = 0;
	int read_errors = 0;
	integer seed;
	logic [`SOC_ADDR_W-1:0] ram_addr [N_WORDS];

	soc soc_inst (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_pa_request(i_pa_request),
		.i_pa_address(i_pa_address),
		.o_pa_ready(o_pa_ready),
		.o_pa_rdata(o_pa_rdata),
		.i_pb_request(i_pb_request),
		.i_pb_rw(i_pb_rw),
		.i_pb_address(i_pb_address),
		.i_pb_wdata(i_pb_wdata),
		.o_pb_ready(o_pb_ready),
		.o_pb_rdata(o_pb_rdata),
		.o_ledr(o_ledr),
		.o_timer_irq(o_timer_irq),
		.o_bus_fault(o_bus_fault),
		.o_fault_address(o_fault_address),
		.o_fault_src(o_fault_src)
	);

	always #5 i_clock = ~i_clock;

	//======================================================================
	// Reference model
	function automatic logic [`SOC_DATA_W-1:0] expected_read(input logic [`SOC_ADDR_W-1:0] addr);
		int idx;
		idx = int'((addr >> 2) % `SOC_RAM_WORDS);
		if (addr[31:28] == 4'(`SOC_SEL_RAM))
			return ram_model[idx];
		if (addr[31:28] == 4'(`SOC_SEL_BRIDGE) && addr[27:24] == 4'(`SOC_FAR_LED))
			return {{(`SOC_DATA_W-`SOC_LED_W){1'b0}}, led_model};
		// Unmapped and unknown far targets read as zero
		return '0;
	endfunction

	task automatic store_write(input logic [`SOC_ADDR_W-1:0] addr,
		input logic [`SOC_DATA_W-1:0] data);
		int idx;
		idx = int'((addr >> 2) % `SOC_RAM_WORDS);
		if (addr[31:28] == 4'(`SOC_SEL_RAM))
			ram_model[idx] = data;
		else if (addr[31:28] == 4'(`SOC_SEL_BRIDGE) && addr[27:24] == 4'(`SOC_FAR_LED))
			led_model = data[`SOC_LED_W-1:0];
	endtask

	// Port inputs are held through the ready cycle, so they name the access
	always @(negedge i_clock) begin
		if (!i_reset && o_pa_ready && pa_check) begin
			read_checks = read_checks + 1;
			if (o_pa_rdata !== expected_read(i_pa_address)) begin
				read_errors = read_errors + 1;
				$display("Fail o_pa_rdata at %h: got %h expected %h",
					i_pa_address, o_pa_rdata, expected_read(i_pa_address));
			end
		end
		if (!i_reset && o_pb_ready) begin
			if (i_pb_rw) begin
				store_write(i_pb_address, i_pb_wdata);
			end else if (pb_check) begin
				read_checks = read_checks + 1;
				if (o_pb_rdata !== expected_read(i_pb_address)) begin
					read_errors = read_errors + 1;
					$display("Fail o_pb_rdata at %h: got %h expected %h",
						i_pb_address, o_pb_rdata, expected_read(i_pb_address));
				end
			end
		end
	end

	//======================================================================
	// Port handshakes
	task automatic access_port_b(input logic rw, input logic [`SOC_ADDR_W-1:0] addr,
		input logic [`SOC_DATA_W-1:0] wdata, input logic check,
		output logic [`SOC_DATA_W-1:0] rdata);
		@(posedge i_clock);
		pb_check = check;
		i_pb_request <= 1'b1;
		i_pb_rw <= rw;
		i_pb_address <= addr;
		i_pb_wdata <= wdata;
		@(negedge i_clock);
		while (o_pb_ready !== 1'b1)
			@(negedge i_clock);
		rdata = o_pb_rdata;
		@(posedge i_clock);
		i_pb_request <= 1'b0;
	endtask

	task automatic read_port_a(input logic [`SOC_ADDR_W-1:0] addr, input logic check,
		output logic [`SOC_DATA_W-1:0] rdata);
		@(posedge i_clock);
		pa_check = check;
		i_pa_request <= 1'b1;
		i_pa_address <= addr;
		@(negedge i_clock);
		while (o_pa_ready !== 1'b1)
			@(negedge i_clock);
		rdata = o_pa_rdata;
		@(posedge i_clock);
		i_pa_request <= 1'b0;
	endtask

	task automatic check_fault(input logic [`SOC_ADDR_W-1:0] addr);
		checks = checks + 3;
		if (o_bus_fault !== 1'b1) begin
			errors = errors + 1;
			$display("Fail o_bus_fault: got %h expected %h", o_bus_fault, 1'b1);
		end
		if (o_fault_address !== addr) begin
			errors = errors + 1;
			$display("Fail o_fault_address: got %h expected %h", o_fault_address, addr);
		end
		if (o_fault_src !== FAULT_DBUS) begin
			errors = errors + 1;
			$display("Fail o_fault_src: got %h expected %h", o_fault_src, FAULT_DBUS);
		end
	endtask

	task automatic report_test(input int number, input string name, input int err_start);
		if (errors + read_errors == err_start)
			$display("[%0d] %s: ok", number, name);
		else
			$display("[%0d] %s: %0d errors", number, name, errors + read_errors - err_start);
	endtask

	//======================================================================
	// Stimulus
	initial begin
		logic [`SOC_DATA_W-1:0] data;
		logic [`SOC_DATA_W-1:0] data_a;
		logic [`SOC_DATA_W-1:0] data_b;
		logic [`SOC_DATA_W-1:0] count_0;
		logic [`SOC_DATA_W-1:0] count_1;
		logic [`SOC_ADDR_W-1:0] bad_addr;
		int err_start;
		int pick_a;
		int pick_b;
		int waited;

		seed = 32'h882b;
		checks = 0;
		errors = 0;
		pa_check = 1'b0;
		pb_check = 1'b0;
		i_reset <= 1'b1;
		i_pa_request <= 1'b0;
		i_pa_address <= '0;
		i_pb_request <= 1'b0;
		i_pb_rw <= 1'b0;
		i_pb_address <= '0;
		i_pb_wdata <= '0;
		repeat (10) @(posedge i_clock);
		i_reset <= 1'b0;

		// RAM writes, then reads on port B
		err_start = errors + read_errors;
		for (int i = 0; i < N_WORDS; i++) begin
			ram_addr[i] = {4'(`SOC_SEL_RAM), 28'($random(seed)) & 28'hffffffc};
			access_port_b(1'b1, ram_addr[i], $random(seed), 1'b0, data);
		end
		for (int i = 0; i < N_WORDS; i++)
			access_port_b(1'b0, ram_addr[i], '0, 1'b1, data);
		report_test(1, "ram write and read back on port B", err_start);

		err_start = errors + read_errors;
		for (int i = 0; i < N_WORDS; i++)
			read_port_a(ram_addr[i], 1'b1, data);
		report_test(2, "ram read on port A", err_start);

		// Both ports start in the same cycle
		err_start = errors + read_errors;
		for (int i = 0; i < N_PAIRS; i++) begin
			pick_a = {$random(seed)} % N_WORDS;
			pick_b = {$random(seed)} % N_WORDS;
			fork
				read_port_a(ram_addr[pick_a], 1'b1, data_a);
				access_port_b(1'b0, ram_addr[pick_b], '0, 1'b1, data_b);
			join
		end
		report_test(3, "concurrent port A and B reads", err_start);

		err_start = errors + read_errors;
		data = $random(seed);
		access_port_b(1'b1, LED_ADDR, data, 1'b0, data_b);
		@(negedge i_clock);
		checks = checks + 1;
		if (o_ledr !== data[`SOC_LED_W-1:0]) begin
			errors = errors + 1;
			$display("Fail o_ledr: got %h expected %h", o_ledr, data[`SOC_LED_W-1:0]);
		end
		access_port_b(1'b0, LED_ADDR, '0, 1'b1, data_b);
		report_test(4, "led register", err_start);

		// Timer counter, compare and interrupt
		err_start = errors + read_errors;
		access_port_b(1'b0, TIMER_COUNT, '0, 1'b0, count_0);
		access_port_b(1'b0, TIMER_COUNT, '0, 1'b0, count_1);
		checks = checks + 1;
		if (count_1 <= count_0) begin
			errors = errors + 1;
			$display("Fail timer counter: got %h after %h, expected a larger value",
				count_1, count_0);
		end
		access_port_b(1'b1, TIMER_COMPARE, count_1 + 32'd20, 1'b0, data);
		waited = 0;
		@(negedge i_clock);
		while (o_timer_irq !== 1'b1 && waited < 100) begin
			@(negedge i_clock);
			waited = waited + 1;
		end
		checks = checks + 1;
		if (o_timer_irq !== 1'b1) begin
			errors = errors + 1;
			$display("timer interrupt did not rise within 100 cycles of the compare write");
		end
		access_port_b(1'b1, TIMER_COMPARE, 32'hffff_ffff, 1'b0, data);
		@(negedge i_clock);
		checks = checks + 1;
		if (o_timer_irq !== 1'b0) begin
			errors = errors + 1;
			$display("Fail o_timer_irq: got %h expected %h", o_timer_irq, 1'b0);
		end
		report_test(5, "timer counter and interrupt", err_start);

		// Unmapped reads and the sticky first fault
		err_start = errors + read_errors;
		checks = checks + 1;
		if (o_bus_fault !== 1'b0) begin
			errors = errors + 1;
			$display("Fail o_bus_fault: got %h expected %h", o_bus_fault, 1'b0);
		end
		bad_addr = {4'h3, 28'($random(seed))};
		access_port_b(1'b0, bad_addr, '0, 1'b1, data);
		@(negedge i_clock);
		check_fault(bad_addr);
		read_port_a({4'h7, 28'($random(seed))}, 1'b1, data);
		@(negedge i_clock);
		check_fault(bad_addr);
		report_test(6, "unmapped access and sticky fault", err_start);

		$display("checks %0d, errors %0d", checks + read_checks, errors + read_errors);
		if (errors + read_errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge i_clock);
		$display("watchdog expired after %0d cycles, a handshake never completed",
			WATCHDOG_CYCLES);
		$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire
